//--- include/modArith_params.svh
`ifndef MOD_ARITH_PARAMS_SVH
`define MOD_ARITH_PARAMS_SVH

// Operand and modulus width
`define WORD_BITS 1027

// Carry-select segment width, the top segment takes the remainder
`define SEG_BITS 128
`define NUM_SEGS ((`WORD_BITS + `SEG_BITS - 1) / `SEG_BITS)

// Cycles from req sampled high to ack rising
`define ACK_LATENCY 4

`endif

//--- design/mpArithPkg.sv
`default_nettype none

`include "modArith_params.svh"

package mpArithPkg;

  // One full-width operand, modulus or residue
  typedef logic [`WORD_BITS-1:0] operand_t;

  // Adder result
  // flag is the carry-out for an add and the borrow for a subtract
  typedef struct packed {
    logic     flag;
    operand_t value;
  } sumWord_t;

endpackage

`default_nettype wire

//--- design/modCtrlPkg.sv
`default_nettype none

package modCtrlPkg;

  import mpArithPkg::*;

  typedef enum logic {
    MOD_ADD = 1'b0,
    MOD_SUB = 1'b1
  } modOp_e;

  // One transaction as presented by the requester, a and b below modulus
  typedef struct packed {
    modOp_e   op;
    operand_t a;
    operand_t b;
    operand_t modulus;
  } modRequest_t;

  // Two passes through the adder, each with a one-cycle wait for the sum
  typedef enum logic [2:0] {
    IDLE,
    PASS1,
    WAIT1,
    PASS2,
    WAIT2,
    DONE
  } ctrlState_e;

endpackage

`default_nettype wire

//--- design/segmentAdder.sv
`default_nettype none

`include "modArith_params.svh"

// Both carry-in cases of one segment, so the select stage only has to choose
module segmentAdder #(
  parameter int width = `SEG_BITS
) (
  input  wire logic [width-1:0] a,
  input  wire logic [width-1:0] b,
  output logic      [width-1:0] sum0,
  output logic      [width-1:0] sum1,
  output logic                  carry0,
  output logic                  carry1
);

  logic [width:0] sumNoCarry;
  logic [width:0] sumWithCarry;

  assign sumNoCarry   = {1'b0, a} + {1'b0, b};
  assign sumWithCarry = {1'b0, a} + {1'b0, b} + {{width{1'b0}}, 1'b1};

  assign sum0   = sumNoCarry[width-1:0];
  assign carry0 = sumNoCarry[width];

  assign sum1   = sumWithCarry[width-1:0];
  assign carry1 = sumWithCarry[width];

endmodule

`default_nettype wire

//--- design/carrySelectAdder.sv
`default_nettype none

`include "modArith_params.svh"

module carrySelectAdder
  import mpArithPkg::*;
(
  input  wire           clk,
  input  wire           rstN,
  input  wire           subtract,
  input  wire operand_t addA,
  input  wire operand_t addB,
  output sumWord_t      sum
);

  localparam int WordBits = `WORD_BITS;
  localparam int SegBits  = `SEG_BITS;
  localparam int NumSegs  = `NUM_SEGS;
  localparam int TopBits  = WordBits - (NumSegs - 1) * SegBits;

  operand_t bMux;

  // Candidate sums, Lo for carry-in 0 and Hi for carry-in 1
  // Segment 0 has its real carry-in and therefore only one candidate
  logic [WordBits-1:0]        sumLo;
  logic [WordBits-1:SegBits]  sumHi;
  logic [NumSegs-1:0]         carryLo;
  logic [NumSegs-1:1]         carryHi;
  logic [SegBits:0]           seg0Sum;

  logic [WordBits-1:0]        sumLoQ;
  logic [WordBits-1:SegBits]  sumHiQ;
  logic [NumSegs-1:0]         carryLoQ;
  logic [NumSegs-1:1]         carryHiQ;
  logic                       subQ;

  logic [NumSegs-1:0]         selCarry;
  logic [WordBits-1:0]        sumValue;

  // Subtraction as a + ~b + 1
  assign bMux = subtract ? ~addB : addB;

  assign seg0Sum = {1'b0, addA[SegBits-1:0]} + {1'b0, bMux[SegBits-1:0]}
                 + {{SegBits{1'b0}}, subtract};
  assign sumLo[SegBits-1:0] = seg0Sum[SegBits-1:0];
  assign carryLo[0]         = seg0Sum[SegBits];

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      carryLoQ <= '0;
      carryHiQ <= '0;
      subQ     <= 1'b0;
    end
    else
    begin
      carryLoQ <= carryLo;
      carryHiQ <= carryHi;
      subQ     <= subtract;
    end
  end

  always_ff @(posedge clk)
  begin
    sumLoQ <= sumLo;
    sumHiQ <= sumHi;
  end

  assign selCarry[0]           = carryLoQ[0];
  assign sumValue[SegBits-1:0] = sumLoQ[SegBits-1:0];

  for (genvar s = 1; s < NumSegs; s++)
  begin : gSeg
    localparam int segLo = s * SegBits;
    localparam int segW  = (s == NumSegs - 1) ? TopBits : SegBits;

    segmentAdder #(
      .width(segW)
    ) segAdd (
      .a     (addA[segLo +: segW]),
      .b     (bMux[segLo +: segW]),
      .sum0  (sumLo[segLo +: segW]),
      .sum1  (sumHi[segLo +: segW]),
      .carry0(carryLo[s]),
      .carry1(carryHi[s])
    );

    // Select stage after the register, rippling one mux per segment
    assign selCarry[s] = selCarry[s-1] ? carryHiQ[s] : carryLoQ[s];
    assign sumValue[segLo +: segW] = selCarry[s-1] ? sumHiQ[segLo +: segW]
                                                   : sumLoQ[segLo +: segW];
  end

  // A subtract without carry-out means a borrow
  assign sum = '{flag: selCarry[NumSegs-1] ^ subQ, value: sumValue};

endmodule

`default_nettype wire

//--- design/modAddController.sv
`default_nettype none

// Four-phase requester side and the two adder passes
// IDLE  samples req, edge 0
// PASS1 a +/- b into the adder
// WAIT1 r1 on the adder output
// PASS2 r1 -/+ modulus into the adder
// WAIT2 r2 on the adder output, captured at edge 4
// DONE  ack high, which gives ACK_LATENCY = 4
module modAddController
  import mpArithPkg::*;
  import modCtrlPkg::*;
(
  input  wire              clk,
  input  wire              rstN,
  input  wire              req,
  input  wire modRequest_t request,
  output logic             ack,
  output operand_t         result,
  output operand_t         addA,
  output operand_t         addB,
  output logic             subtract,
  input  wire sumWord_t    sum
);

  ctrlState_e  state;
  ctrlState_e  stateNext;
  modRequest_t reqQ;
  sumWord_t    r1Q;
  sumWord_t    r2Q;
  logic        secondPass;
  logic        useR2;

  always_comb
  begin
    stateNext = state;
    case (state)
      IDLE:
      begin
        if (req)
        begin
          stateNext = PASS1;
        end
      end
      PASS1:   stateNext = WAIT1;
      WAIT1:   stateNext = PASS2;
      PASS2:   stateNext = WAIT2;
      WAIT2:   stateNext = DONE;
      DONE:
      begin
        // Hold the answer as long as the requester keeps req high
        if (!req)
        begin
          stateNext = IDLE;
        end
      end
      default: stateNext = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      state <= IDLE;
    end
    else
    begin
      state <= stateNext;
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == IDLE && req)
    begin
      reqQ <= request;
    end
  end

  // Zero residues after reset make result read zero for either op
  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      r1Q <= '0;
      r2Q <= '0;
    end
    else
    begin
      if (state == WAIT1)
      begin
        r1Q <= sum;
      end
      if (state == WAIT2)
      begin
        r2Q <= sum;
      end
    end
  end

  // Second pass corrects with the modulus in the opposite direction
  assign secondPass = (state == PASS2);
  assign addA       = secondPass ? r1Q.value : reqQ.a;
  assign addB       = secondPass ? reqQ.modulus : reqQ.b;
  assign subtract   = (reqQ.op == MOD_SUB) ^ secondPass;

  // Add: keep a+b-n unless a+b was already below n
  // Sub: add n back only when a-b borrowed
  assign useR2 = (reqQ.op == MOD_ADD) ? (r1Q.flag | ~r2Q.flag) : r1Q.flag;

  assign result = useR2 ? r2Q.value : r1Q.value;
  assign ack    = (state == DONE);

endmodule

`default_nettype wire

//--- design/modAddUnit.sv
`default_nettype none

module modAddUnit
  import mpArithPkg::*;
  import modCtrlPkg::*;
(
  input  wire              clk,
  input  wire              rstN,
  input  wire              req,
  input  wire modRequest_t request,
  output logic             ack,
  output operand_t         result
);

  operand_t addA;
  operand_t addB;
  logic     subtract;
  sumWord_t sum;

  modAddController ctrl (
    .clk     (clk),
    .rstN    (rstN),
    .req     (req),
    .request (request),
    .ack     (ack),
    .result  (result),
    .addA    (addA),
    .addB    (addB),
    .subtract(subtract),
    .sum     (sum)
  );

  // Shared by both passes, one cycle from operands to sum
  carrySelectAdder adder (
    .clk     (clk),
    .rstN    (rstN),
    .subtract(subtract),
    .addA    (addA),
    .addB    (addB),
    .sum     (sum)
  );

endmodule

`default_nettype wire

//--- tb/modAddUnit_props.sv
`default_nettype none

`include "modArith_params.svh"

// Handshake timing of the requester side
module modAddUnitProps
  import mpArithPkg::*;
(
  input wire logic     clk,
  input wire logic     rstN,
  input wire logic     req,
  input wire logic     ack,
  input wire operand_t result
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int Lat = `ACK_LATENCY;

  int   failCount = 0;
  logic reqSeen;

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      reqSeen <= 1'b0;
    end
    else if (req)
    begin
      reqSeen <= 1'b1;
    end
  end

  ackLowInReset: assert property (@(posedge clk) !rstN |-> !ack)
  else
  begin
    failCount++;
    $error("ack high while reset is asserted");
  end

  ackLowBeforeReq: assert property (@(posedge clk) disable iff (!rstN) !reqSeen |-> !ack)
  else
  begin
    failCount++;
    $error("ack high before the first req");
  end

  // req first sampled high at edge 0 means ack rises right after edge Lat
  ackLatency: assert property (@(posedge clk) disable iff (!rstN)
    ($past(req, Lat + 1) && !$past(req, Lat + 2)) |-> (ack && !$past(ack)))
  else
  begin
    failCount++;
    $error("ack did not rise %0d cycles after req", Lat);
  end

  ackOnlyWithReq: assert property (@(posedge clk) disable iff (!rstN) ack |-> $past(req))
  else
  begin
    failCount++;
    $error("ack high without a preceding req");
  end

  holdWhileReq: assert property (@(posedge clk) disable iff (!rstN)
    $past(ack && req) |-> (ack && $stable(result)))
  else
  begin
    failCount++;
    $error("ack or result changed while req was held high");
  end

  ackFall: assert property (@(posedge clk) disable iff (!rstN) $past(ack && !req) |-> !ack)
  else
  begin
    failCount++;
    $error("ack still high one cycle after req dropped");
  end

endmodule

bind modAddUnit modAddUnitProps props (
  .clk   (clk),
  .rstN  (rstN),
  .req   (req),
  .ack   (ack),
  .result(result)
);

`default_nettype wire

//--- tb/modAddUnit_tb.sv
`default_nettype none

`include "modArith_params.svh"

module modAddUnit_tb
  import mpArithPkg::*;
  import modCtrlPkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int Period        = 40;
  localparam int ResetCycles   = 16;
  localparam int Lat           = `ACK_LATENCY;
  localparam int Pieces        = (`WORD_BITS + 31) / 32;
  localparam int RandomCount   = 200;
  localparam int HoldCount     = 40;
  localparam int MaxHold       = 10;
  localparam int CarryCount    = 4 + 2 * (`NUM_SEGS - 1);
  localparam int TotalTrans    = 2 * RandomCount + CarryCount + HoldCount;
  // Twice the expected run length
  localparam int TimeoutCycles =
    2 * (TotalTrans * (Lat + 4) + HoldCount * MaxHold + ResetCycles);

  logic        clk;
  logic        rstN;
  logic        req;
  modRequest_t request;
  logic        ack;
  operand_t    result;

  int errorCount;
  int transCount;
  int testCount;
  int testsPassed;

  modAddUnit modAddUnit_i (
    .clk    (clk),
    .rstN   (rstN),
    .req    (req),
    .request(request),
    .ack    (ack),
    .result (result)
  );

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #(Period / 2) clk = ~clk;
    end
  end

  initial
  begin
    #(TimeoutCycles * Period);
    $display("Timeout: the run did not finish within %0d clock cycles", TimeoutCycles);
    $display("Test failed");
    $finish;
  end

  function automatic int failureTotal();
    return errorCount + modAddUnit_i.props.failCount;
  endfunction

  function automatic operand_t randomWord();
    logic [Pieces*32-1:0] wide;
    wide = '0;
    for (int i = 0; i < Pieces; i++)
    begin
      wide[i*32 +: 32] = $urandom();
    end
    return wide[`WORD_BITS-1:0];
  endfunction

  function automatic operand_t randomModulus();
    operand_t n;
    n = randomWord();
    if (n == '0)
    begin
      n = operand_t'(1);
    end
    return n;
  endfunction

  // Reference residues in one bit more than the word
  function automatic operand_t modAddRef(operand_t a, operand_t b, operand_t n);
    logic [`WORD_BITS:0] s;
    s = {1'b0, a} + {1'b0, b};
    if (s >= {1'b0, n})
    begin
      s = s - {1'b0, n};
    end
    return s[`WORD_BITS-1:0];
  endfunction

  function automatic operand_t modSubRef(operand_t a, operand_t b, operand_t n);
    logic [`WORD_BITS:0] d;
    if (a >= b)
    begin
      d = {1'b0, a} - {1'b0, b};
    end
    else
    begin
      d = {1'b0, a} + {1'b0, n} - {1'b0, b};
    end
    return d[`WORD_BITS-1:0];
  endfunction

  // One four-phase transaction, entered and left 2 ns after a rising edge
  task automatic exchange(input modOp_e op, input operand_t a, input operand_t b,
                          input operand_t n, input int holdCycles);
    modRequest_t r;
    operand_t    expected;
    r.op      = op;
    r.a       = a;
    r.b       = b;
    r.modulus = n;
    expected  = (op == MOD_ADD) ? modAddRef(a, b, n) : modSubRef(a, b, n);
    request   = r;
    req       = 1'b1;
    @(negedge clk);
    while (!ack)
    begin
      @(negedge clk);
    end
    resultCheck: assert (result == expected)
    else
    begin
      $display("MISMATCH at %0t ns: result got %h expected %h", $time, result, expected);
      errorCount++;
    end
    repeat (holdCycles + 1)
    begin
      @(posedge clk);
    end
    #2;
    req = 1'b0;
    @(negedge clk);
    while (ack)
    begin
      @(negedge clk);
    end
    @(posedge clk);
    #2;
    transCount++;
  endtask

  task automatic randomOps(input modOp_e op);
    operand_t n;
    operand_t a;
    operand_t b;
    for (int i = 0; i < RandomCount; i++)
    begin
      n = randomModulus();
      a = randomWord() % n;
      b = randomWord() % n;
      // Every tenth subtraction has equal operands
      if (op == MOD_SUB && i % 10 == 0)
      begin
        b = a;
      end
      exchange(op, a, b, n, 0);
    end
  endtask

  // All-ones modulus, carries and borrows through whole segments
  task automatic carryCases();
    operand_t ones;
    operand_t low;
    ones = '1;
    exchange(MOD_ADD, ones - operand_t'(1), ones - operand_t'(1), ones, 0);
    exchange(MOD_SUB, ones - operand_t'(1), ones - operand_t'(1), ones, 0);
    exchange(MOD_ADD, ones - operand_t'(1), operand_t'(1), ones, 0);
    exchange(MOD_SUB, '0, ones - operand_t'(1), ones, 0);
    for (int k = 1; k < `NUM_SEGS; k++)
    begin
      low = (operand_t'(1) << (k * `SEG_BITS)) - operand_t'(1);
      exchange(MOD_ADD, low, operand_t'(1), ones, 0);
      exchange(MOD_SUB, low + operand_t'(1), operand_t'(1), ones, 0);
    end
  endtask

  task automatic holdCases();
    operand_t n;
    int       hold;
    for (int i = 0; i < HoldCount; i++)
    begin
      n    = randomModulus();
      hold = $urandom_range(MaxHold, 0);
      exchange(modOp_e'(i % 2), randomWord() % n, randomWord() % n, n, hold);
    end
  endtask

  task automatic reportTest(input string name, input int failsBefore);
    int fails;
    fails = failureTotal() - failsBefore;
    testCount++;
    if (fails == 0)
    begin
      testsPassed++;
      $display("test %s: PASS", name);
    end
    else
    begin
      $display("test %s: FAIL with %0d failed checks", name, fails);
    end
  endtask

  initial
  begin
    int mark;
    rstN        = 1'b0;
    req         = 1'b0;
    request     = '0;
    errorCount  = 0;
    transCount  = 0;
    testCount   = 0;
    testsPassed = 0;
    void'($urandom(86));
    mark = 0;
    repeat (ResetCycles)
    begin
      @(posedge clk);
    end
    #2;
    rstN = 1'b1;
    // Idle cycles so the props see ack low before any req
    repeat (4)
    begin
      @(posedge clk);
    end
    #2;
    reportTest("reset", mark);
    mark = failureTotal();
    randomOps(MOD_ADD);
    reportTest("randomAdd", mark);
    mark = failureTotal();
    randomOps(MOD_SUB);
    reportTest("randomSub", mark);
    mark = failureTotal();
    carryCases();
    reportTest("carryChain", mark);
    mark = failureTotal();
    holdCases();
    reportTest("handshake", mark);
    $display("%0d of %0d tests passed, %0d transactions, %0d failed checks",
             testsPassed, testCount, transCount, failureTotal());
    if (failureTotal() == 0)
    begin
      $display("Test completed successfully");
    end
    else
    begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+include
design/mpArithPkg.sv
design/modCtrlPkg.sv
design/segmentAdder.sv
design/carrySelectAdder.sv
design/modAddController.sv
design/modAddUnit.sv
tb/modAddUnit_props.sv
tb/modAddUnit_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the modAddUnit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module modAddUnit_tb -f filelist.f -o modAddUnit_sim

status=0
./obj_dir/modAddUnit_sim +verilator+error+limit+1000 > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Test failed" sim.log || [ "$status" -ne 0 ]; then
  echo "Simulation FAILED, see sim.log"
  exit 1
fi
echo "Simulation passed"
exit 0
